/* booth_pkg.sv */
/*
  Sizes and encodings for the radix-2 Booth multiplier core.
  Operands are signed two's complement. The product is exact for all
  operand pairs, -128 times -128 included.
*/
`default_nettype none

package booth_pkg;

  // Operand width in bits
  localparam int WIDTH = 8;

  // Full signed product
  localparam int PROD_WIDTH = 2 * WIDTH;

  // Must hold the value WIDTH
  localparam int CNT_WIDTH = 4;

  // Number of shift steps per multiplication, as a counter value
  localparam logic [CNT_WIDTH-1:0] ITERATIONS = CNT_WIDTH'(WIDTH);

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_MULT = 1'b1
  } booth_state_e;

  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_e;

endpackage

`default_nettype wire

/* mem_pkg.sv */
/*
  Shared operand RAM and its arbiter.
  One word per operand or product. Requester indices are fixed.
*/
`default_nettype none

package mem_pkg;

  localparam int ADDR_WIDTH    = 6;
  localparam int RAM_DEPTH     = 1 << ADDR_WIDTH;
  localparam int DATA_WIDTH    = 16;
  localparam int NUM_REQ       = 3;
  localparam int REQ_IDX_WIDTH = 2;

  // Arbiter port of each requester
  localparam logic [REQ_IDX_WIDTH-1:0] REQ_HOST = 2'd0;
  localparam logic [REQ_IDX_WIDTH-1:0] REQ_U0   = 2'd1;
  localparam logic [REQ_IDX_WIDTH-1:0] REQ_U1   = 2'd2;

endpackage

`default_nettype wire

/* booth_controller.sv */
/*
  Booth control FSM. start is honoured only in ST_IDLE.
  load is combinational from start. ready and clear pulse together
  on the cycle after the last iteration.
*/
`default_nettype none

module booth_controller (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               q0,
  input  logic               q_1,
  input  logic               cnt_done,
  output logic               load,
  output logic               add_en,
  output booth_pkg::alu_op_e alu_op,
  output logic               count_en,
  output logic               ready,
  output logic               clear
);

  booth_pkg::booth_state_e state;
  booth_pkg::booth_state_e state_nxt;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= booth_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ************************************************************
  // Strobes for the datapath
  // ************************************************************
  always_comb begin
    state_nxt = state;
    load      = 1'b0;
    add_en    = 1'b0;
    alu_op    = booth_pkg::ALU_ADD;
    count_en  = 1'b0;
    ready     = 1'b0;
    clear     = 1'b0;
    case (state)
      booth_pkg::ST_IDLE: begin
        if (start) begin
          load      = 1'b1;
          state_nxt = booth_pkg::ST_MULT;
        end
      end
      booth_pkg::ST_MULT: begin
        if (cnt_done) begin
          ready     = 1'b1;
          clear     = 1'b1;
          state_nxt = booth_pkg::ST_IDLE;
        end else begin
          count_en = 1'b1;
          // Bit pair is {Q0, Q-1}. Equal bits mean shift only
          case ({q0, q_1})
            2'b10: begin
              add_en = 1'b1;
              alu_op = booth_pkg::ALU_SUB;
            end
            2'b01: begin
              add_en = 1'b1;
              alu_op = booth_pkg::ALU_ADD;
            end
            default: add_en = 1'b0;
          endcase
        end
      end
      default: state_nxt = booth_pkg::ST_IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* booth_datapath.sv */
/*
  Booth datapath with A, Q, Q-1 and M registers.
  A carries one guard bit so that subtracting the most negative
  multiplicand does not overflow. product is valid after ready.
*/
`default_nettype none

module booth_datapath (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [booth_pkg::WIDTH-1:0]      multiplicand,
  input  logic [booth_pkg::WIDTH-1:0]      multiplier,
  input  logic                            load,
  input  logic                            add_en,
  input  booth_pkg::alu_op_e              alu_op,
  input  logic                            count_en,
  input  logic                            clear,
  output logic                            q0,
  output logic                            q_1,
  output logic                            cnt_done,
  output logic [booth_pkg::PROD_WIDTH-1:0] product
);

  logic [booth_pkg::WIDTH:0]           acc;
  logic [booth_pkg::WIDTH-1:0]         q_reg;
  logic [booth_pkg::WIDTH-1:0]         m_reg;
  logic                                q_m1;
  logic [booth_pkg::CNT_WIDTH-1:0]     cnt;
  logic [booth_pkg::WIDTH:0]           m_ext;
  logic [booth_pkg::WIDTH:0]           sum;

  assign m_ext = {m_reg[booth_pkg::WIDTH-1], m_reg};

  always_comb begin
    sum = acc;
    if (add_en) begin
      if (alu_op == booth_pkg::ALU_SUB) begin
        sum = acc - m_ext;
      end else begin
        sum = acc + m_ext;
      end
    end
  end

  // ************************************************************
  // Add and shift in one edge
  // ************************************************************
  always_ff @(posedge clk) begin
    if (load) begin
      acc   <= '0;
      q_reg <= multiplier;
      q_m1  <= 1'b0;
      m_reg <= multiplicand;
    end else if (count_en) begin
      // Arithmetic right shift of {A, Q, Q-1}
      acc   <= {sum[booth_pkg::WIDTH], sum[booth_pkg::WIDTH:1]};
      q_reg <= {sum[0], q_reg[booth_pkg::WIDTH-1:1]};
      q_m1  <= q_reg[0];
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt <= '0;
    end else if (clear || load) begin
      cnt <= '0;
    end else if (count_en) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign cnt_done = (cnt == booth_pkg::ITERATIONS);
  assign q0       = q_reg[0];
  assign q_1      = q_m1;

  // The guard bit only matters during the run
  assign product = {acc[booth_pkg::WIDTH-1:0], q_reg};

endmodule

`default_nettype wire

/* mul_unit.sv */
/*
  One multiplier job engine on the shared RAM port.
  Reads a at base and b at base+1, writes a*b to base+2.
  Only the low WIDTH bits of each operand word are used.
  start is ignored while busy.
*/
`default_nettype none

module mul_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] base,
  output logic                           busy,
  output logic                           done,
  output logic                           mem_req,
  output logic                           mem_we,
  output logic [mem_pkg::ADDR_WIDTH-1:0] mem_addr,
  output logic [mem_pkg::DATA_WIDTH-1:0] mem_wdata,
  input  logic                           mem_gnt,
  input  logic [mem_pkg::DATA_WIDTH-1:0] mem_rdata
);

  typedef enum logic [2:0] {
    J_IDLE,
    J_RD_A,
    J_RD_B,
    J_LOAD,
    J_CORE,
    J_WRITE,
    J_DONE
  } job_state_e;

  job_state_e                          state;
  job_state_e                          state_nxt;
  logic [mem_pkg::ADDR_WIDTH-1:0]      base_q;
  logic [booth_pkg::WIDTH-1:0]         mcand_q;
  logic                                a_pending;
  logic                                core_start;
  logic                                core_ready;
  logic                                load;
  logic                                add_en;
  booth_pkg::alu_op_e                  alu_op;
  logic                                count_en;
  logic                                clear;
  logic                                q0;
  logic                                q_1;
  logic                                cnt_done;
  logic [booth_pkg::PROD_WIDTH-1:0]    product;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= J_IDLE;
      a_pending <= 1'b0;
    end else begin
      state     <= state_nxt;
      a_pending <= (state == J_RD_A) && mem_gnt;
    end
  end

  // Word a returns while the read of b is being requested
  always_ff @(posedge clk) begin
    if (state == J_IDLE && start) begin
      base_q <= base;
    end
    if (a_pending) begin
      mcand_q <= mem_rdata[booth_pkg::WIDTH-1:0];
    end
  end

  // ************************************************************
  // Job sequencer
  // ************************************************************
  always_comb begin
    state_nxt = state;
    case (state)
      J_IDLE:  if (start) state_nxt = J_RD_A;
      J_RD_A:  if (mem_gnt) state_nxt = J_RD_B;
      J_RD_B:  if (mem_gnt) state_nxt = J_LOAD;
      J_LOAD:  state_nxt = J_CORE;
      J_CORE: begin
        if (core_ready) begin
          state_nxt = mem_gnt ? J_DONE : J_WRITE;
        end
      end
      J_WRITE: if (mem_gnt) state_nxt = J_DONE;
      J_DONE:  state_nxt = J_IDLE;
      default: state_nxt = J_IDLE;
    endcase
  end

  always_comb begin
    mem_req    = 1'b0;
    mem_we     = 1'b0;
    mem_addr   = base_q;
    core_start = 1'b0;
    case (state)
      J_RD_A: mem_req = 1'b1;
      J_RD_B: begin
        mem_req  = 1'b1;
        mem_addr = base_q + 1'b1;
      end
      J_LOAD: core_start = 1'b1;
      J_CORE: begin
        // The write is offered in the ready cycle itself
        mem_req  = core_ready;
        mem_we   = core_ready;
        mem_addr = base_q + 2'd2;
      end
      J_WRITE: begin
        mem_req  = 1'b1;
        mem_we   = 1'b1;
        mem_addr = base_q + 2'd2;
      end
      default: mem_req = 1'b0;
    endcase
  end

  assign mem_wdata = product;
  assign busy      = (state != J_IDLE);
  assign done      = (state == J_DONE);

  // b goes straight from the read port into the core on load
  booth_controller u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .start    (core_start),
    .q0       (q0),
    .q_1      (q_1),
    .cnt_done (cnt_done),
    .load     (load),
    .add_en   (add_en),
    .alu_op   (alu_op),
    .count_en (count_en),
    .ready    (core_ready),
    .clear    (clear)
  );

  booth_datapath u_dp (
    .clk          (clk),
    .rst          (rst),
    .multiplicand (mcand_q),
    .multiplier   (mem_rdata[booth_pkg::WIDTH-1:0]),
    .load         (load),
    .add_en       (add_en),
    .alu_op       (alu_op),
    .count_en     (count_en),
    .clear        (clear),
    .q0           (q0),
    .q_1          (q_1),
    .cnt_done     (cnt_done),
    .product      (product)
  );

endmodule

`default_nettype wire

/* mem_arbiter.sv */
/*
  Round-robin arbiter for the single RAM port.
  gnt is combinational from req. Read data goes back only to the
  requester granted a read on the previous cycle, others see zero.
*/
`default_nettype none

module mem_arbiter (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic [mem_pkg::NUM_REQ-1:0]                          req,
  input  logic [mem_pkg::NUM_REQ-1:0]                          we,
  input  logic [mem_pkg::NUM_REQ-1:0][mem_pkg::ADDR_WIDTH-1:0] addr,
  input  logic [mem_pkg::NUM_REQ-1:0][mem_pkg::DATA_WIDTH-1:0] wdata,
  output logic [mem_pkg::NUM_REQ-1:0]                          gnt,
  output logic                                                 ram_we,
  output logic [mem_pkg::ADDR_WIDTH-1:0]                       ram_addr,
  output logic [mem_pkg::DATA_WIDTH-1:0]                       ram_wdata,
  input  logic [mem_pkg::DATA_WIDTH-1:0]                       ram_rdata,
  output logic [mem_pkg::NUM_REQ-1:0][mem_pkg::DATA_WIDTH-1:0] rdata
);

  logic [mem_pkg::REQ_IDX_WIDTH-1:0] last;
  logic [mem_pkg::REQ_IDX_WIDTH-1:0] win;
  logic                              found;
  logic [mem_pkg::NUM_REQ-1:0]       rd_sel;

  // Search starts one past the last winner
  always_comb begin
    int cand;
    found = 1'b0;
    win   = '0;
    gnt   = '0;
    for (int i = 1; i <= mem_pkg::NUM_REQ; i++) begin
      cand = (int'(last) + i) % mem_pkg::NUM_REQ;
      if (!found && req[cand]) begin
        found     = 1'b1;
        win       = cand[mem_pkg::REQ_IDX_WIDTH-1:0];
        gnt[cand] = 1'b1;
      end
    end
  end

  assign ram_we    = found && we[win];
  assign ram_addr  = addr[win];
  assign ram_wdata = wdata[win];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // Host gets first pick after reset
      last   <= mem_pkg::REQ_U1;
      rd_sel <= '0;
    end else begin
      if (found) begin
        last <= win;
      end
      rd_sel <= gnt & ~we;
    end
  end

  always_comb begin
    for (int i = 0; i < mem_pkg::NUM_REQ; i++) begin
      rdata[i] = rd_sel[i] ? ram_rdata : '0;
    end
  end

endmodule

`default_nettype wire

/* operand_ram.sv */
/*
  Single-port operand RAM, 64 x 16.
  Read data is registered and shows old contents on a write cycle.
  Contents are undefined until written.
*/
`default_nettype none

module operand_ram (
  input  logic                           clk,
  input  logic                           we,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] addr,
  input  logic [mem_pkg::DATA_WIDTH-1:0] wdata,
  output logic [mem_pkg::DATA_WIDTH-1:0] rdata
);

  logic [mem_pkg::DATA_WIDTH-1:0] mem [mem_pkg::RAM_DEPTH];

  // One access per cycle through the arbiter
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* mul_subsystem.sv */
/*
  Two Booth multiplier units and a host port sharing one RAM.
  Host follows the req/gnt rule of the arbiter. start and done
  are single-cycle pulses.
*/
`default_nettype none

module mul_subsystem (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           host_req,
  input  logic                           host_we,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] host_addr,
  input  logic [mem_pkg::DATA_WIDTH-1:0] host_wdata,
  output logic                           host_gnt,
  output logic [mem_pkg::DATA_WIDTH-1:0] host_rdata,
  input  logic                           start0,
  input  logic                           start1,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] base0,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] base1,
  output logic                           busy0,
  output logic                           busy1,
  output logic                           done0,
  output logic                           done1
);

  logic [mem_pkg::NUM_REQ-1:0]                          req;
  logic [mem_pkg::NUM_REQ-1:0]                          we;
  logic [mem_pkg::NUM_REQ-1:0]                          gnt;
  logic [mem_pkg::NUM_REQ-1:0][mem_pkg::ADDR_WIDTH-1:0] addr;
  logic [mem_pkg::NUM_REQ-1:0][mem_pkg::DATA_WIDTH-1:0] wdata;
  logic [mem_pkg::NUM_REQ-1:0][mem_pkg::DATA_WIDTH-1:0] rdata;
  logic                                                 ram_we;
  logic [mem_pkg::ADDR_WIDTH-1:0]                       ram_addr;
  logic [mem_pkg::DATA_WIDTH-1:0]                       ram_wdata;
  logic [mem_pkg::DATA_WIDTH-1:0]                       ram_rdata;

  // Host requester slot
  assign req[mem_pkg::REQ_HOST]   = host_req;
  assign we[mem_pkg::REQ_HOST]    = host_we;
  assign addr[mem_pkg::REQ_HOST]  = host_addr;
  assign wdata[mem_pkg::REQ_HOST] = host_wdata;
  assign host_gnt                 = gnt[mem_pkg::REQ_HOST];
  assign host_rdata               = rdata[mem_pkg::REQ_HOST];

  mul_unit u0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start0),
    .base      (base0),
    .busy      (busy0),
    .done      (done0),
    .mem_req   (req[mem_pkg::REQ_U0]),
    .mem_we    (we[mem_pkg::REQ_U0]),
    .mem_addr  (addr[mem_pkg::REQ_U0]),
    .mem_wdata (wdata[mem_pkg::REQ_U0]),
    .mem_gnt   (gnt[mem_pkg::REQ_U0]),
    .mem_rdata (rdata[mem_pkg::REQ_U0])
  );

  mul_unit u1 (
    .clk       (clk),
    .rst       (rst),
    .start     (start1),
    .base      (base1),
    .busy      (busy1),
    .done      (done1),
    .mem_req   (req[mem_pkg::REQ_U1]),
    .mem_we    (we[mem_pkg::REQ_U1]),
    .mem_addr  (addr[mem_pkg::REQ_U1]),
    .mem_wdata (wdata[mem_pkg::REQ_U1]),
    .mem_gnt   (gnt[mem_pkg::REQ_U1]),
    .mem_rdata (rdata[mem_pkg::REQ_U1])
  );

  mem_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .gnt       (gnt),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .rdata     (rdata)
  );

  operand_ram u_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

`default_nettype wire

/* mul_subsystem_chk.sv */
/*
  Protocol assertions bound into mul_subsystem.
  fails counts assertion failures and is read by the testbench.
*/
`default_nettype none

module mul_subsystem_chk (
  input logic                        clk,
  input logic                        rst,
  input logic [mem_pkg::NUM_REQ-1:0] gnt,
  input logic                        ram_we,
  input logic                        busy0,
  input logic                        busy1,
  input logic                        done0,
  input logic                        done1
);

  int fails = 0;

  // At most one requester owns the RAM port in a cycle
  grant_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(gnt))
    else begin
      fails++;
      $error("more than one grant in a cycle");
    end

  write_needs_grant: assert property (@(posedge clk) disable iff (!rst)
    ram_we |-> (gnt != '0))
    else begin
      fails++;
      $error("RAM write without a grant");
    end

  // A done pulse closes a job that was running
  done_after_busy: assert property (@(posedge clk) disable iff (!rst)
    ($rose(done0) |-> $past(busy0)) and ($rose(done1) |-> $past(busy1)))
    else begin
      fails++;
      $error("done rose without busy on the previous cycle");
    end

  busy_ends_on_done: assert property (@(posedge clk) disable iff (!rst)
    ($fell(busy0) |-> $past(done0)) and ($fell(busy1) |-> $past(done1)))
    else begin
      fails++;
      $error("busy fell without done");
    end

endmodule

bind mul_subsystem mul_subsystem_chk chk (
  .clk    (clk),
  .rst    (rst),
  .gnt    (gnt),
  .ram_we (ram_we),
  .busy0  (busy0),
  .busy1  (busy1),
  .done0  (done0),
  .done1  (done1)
);

`default_nettype wire

/* tb_mul_subsystem.sv */
/*
  Testbench for mul_subsystem. Jobs are read from mul_patterns.txt
  in the project root. Inputs change 5 units after a rising edge,
  outputs are sampled on the falling edge.
*/
`default_nettype none

module tb_mul_subsystem;

  localparam int NUM_PAT    = 12;
  localparam int NUM_RANDOM = 40;
  localparam int JOB_CYCLES = booth_pkg::WIDTH + 20;
  // Reset, the file jobs plus room for the directed tests, then the random jobs
  localparam int WATCHDOG_CYCLES = 8 + (NUM_PAT + 8) * JOB_CYCLES + NUM_RANDOM * JOB_CYCLES;

  logic                           clk;
  logic                           rst;
  logic                           host_req;
  logic                           host_we;
  logic [mem_pkg::ADDR_WIDTH-1:0] host_addr;
  logic [mem_pkg::DATA_WIDTH-1:0] host_wdata;
  logic                           host_gnt;
  logic [mem_pkg::DATA_WIDTH-1:0] host_rdata;
  logic                           start0;
  logic                           start1;
  logic [mem_pkg::ADDR_WIDTH-1:0] base0;
  logic [mem_pkg::ADDR_WIDTH-1:0] base1;
  logic                           busy0;
  logic                           busy1;
  logic                           done0;
  logic                           done1;

  logic [mem_pkg::DATA_WIDTH-1:0] pat_mem [5 * NUM_PAT];
  integer                         seed = 6221;
  int                             done0_count = 0;
  int                             done1_count = 0;

  mul_subsystem dut (
    .clk        (clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_gnt   (host_gnt),
    .host_rdata (host_rdata),
    .start0     (start0),
    .start1     (start1),
    .base0      (base0),
    .base1      (base1),
    .busy0      (busy0),
    .busy1      (busy1),
    .done0      (done0),
    .done1      (done1)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Done pulses are counted on the edge that ends them
  always @(posedge clk) begin
    if (done0) done0_count <= done0_count + 1;
    if (done1) done1_count <= done1_count + 1;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired: a multiplication job never finished");
    $display("Simulation failed");
    $fatal(1, "watchdog timeout");
  end

  always @(negedge clk) begin
    if (dut.chk.fails != 0) begin
      $display("A protocol assertion in the bound checker failed");
      $display("Simulation failed");
      $fatal(1, "assertion failure");
    end
  end

  // ************************************************************
  // Model and checks
  // ************************************************************
  function automatic logic [booth_pkg::PROD_WIDTH-1:0] ref_product(
    input logic [booth_pkg::WIDTH-1:0] a,
    input logic [booth_pkg::WIDTH-1:0] b
  );
    logic signed [booth_pkg::PROD_WIDTH-1:0] sa;
    logic signed [booth_pkg::PROD_WIDTH-1:0] sb;
    logic signed [booth_pkg::PROD_WIDTH-1:0] p;
    sa = {{booth_pkg::WIDTH{a[booth_pkg::WIDTH-1]}}, a};
    sb = {{booth_pkg::WIDTH{b[booth_pkg::WIDTH-1]}}, b};
    p  = sa * sb;
    return p;
  endfunction

  function automatic logic [mem_pkg::DATA_WIDTH-1:0] sext_word(
    input logic [booth_pkg::WIDTH-1:0] v
  );
    return {{(mem_pkg::DATA_WIDTH - booth_pkg::WIDTH){v[booth_pkg::WIDTH-1]}}, v};
  endfunction

  task automatic check_value(input logic [mem_pkg::DATA_WIDTH-1:0] actual,
                             input logic [mem_pkg::DATA_WIDTH-1:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // ************************************************************
  // Host port and job tasks, all entered 5 units after an edge
  // ************************************************************
  task automatic wait_host_grant();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!host_gnt) begin
      waited++;
      if (waited > 4) begin
        $display("Host request was not granted within 4 cycles");
        $display("Simulation failed");
        $fatal(1, "host starved");
      end
      @(negedge clk);
    end
  endtask

  task automatic host_write(input logic [mem_pkg::ADDR_WIDTH-1:0] addr,
                            input logic [mem_pkg::DATA_WIDTH-1:0] data);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    wait_host_grant();
    @(posedge clk);
    #5;
    host_req = 1'b0;
    host_we  = 1'b0;
    @(posedge clk);
    #5;
  endtask

  task automatic host_read(input logic [mem_pkg::ADDR_WIDTH-1:0] addr,
                           output logic [mem_pkg::DATA_WIDTH-1:0] data);
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    wait_host_grant();
    // Nothing is routed to the host in its own grant cycle
    check_value(host_rdata, '0, "host rdata in the grant cycle");
    @(posedge clk);
    #5;
    host_req = 1'b0;
    @(negedge clk);
    data = host_rdata;
    @(posedge clk);
    #5;
  endtask

  task automatic load_operands(input logic [mem_pkg::ADDR_WIDTH-1:0] base,
                               input logic [booth_pkg::WIDTH-1:0] a,
                               input logic [booth_pkg::WIDTH-1:0] b);
    host_write(base, sext_word(a));
    host_write(base + 6'd1, sext_word(b));
    // Stale product word so that a missing write shows up
    host_write(base + 6'd2, ~ref_product(a, b));
  endtask

  task automatic start_units(input logic go0, input logic go1,
                             input logic [mem_pkg::ADDR_WIDTH-1:0] b0,
                             input logic [mem_pkg::ADDR_WIDTH-1:0] b1);
    start0 = go0;
    start1 = go1;
    base0  = b0;
    base1  = b1;
    @(posedge clk);
    #5;
    start0 = 1'b0;
    start1 = 1'b0;
  endtask

  task automatic wait_done_counts(input int t0, input int t1);
    while (done0_count < t0 || done1_count < t1) @(negedge clk);
    @(posedge clk);
    #5;
  endtask

  task automatic verify_product(input logic [mem_pkg::ADDR_WIDTH-1:0] base,
                                input logic [mem_pkg::DATA_WIDTH-1:0] expected,
                                input string msg);
    logic [mem_pkg::DATA_WIDTH-1:0] got;
    host_read(base + 6'd2, got);
    check_value(got, expected, msg);
  endtask

  task automatic run_job(input logic unit, input logic [mem_pkg::ADDR_WIDTH-1:0] base,
                         input logic [booth_pkg::WIDTH-1:0] a,
                         input logic [booth_pkg::WIDTH-1:0] b);
    int t0;
    int t1;
    load_operands(base, a, b);
    t0 = done0_count;
    t1 = done1_count;
    if (unit) begin
      t1++;
      start_units(1'b0, 1'b1, '0, base);
    end else begin
      t0++;
      start_units(1'b1, 1'b0, base, '0);
    end
    wait_done_counts(t0, t1);
    verify_product(base, ref_product(a, b),
                   $sformatf("unit %0d base %0d product of %h and %h", unit, base, a, b));
  endtask

  // ************************************************************
  // Tests
  // ************************************************************
  task automatic test_host_access();
    logic [mem_pkg::DATA_WIDTH-1:0] got;
    logic [mem_pkg::ADDR_WIDTH-1:0] a;
    for (int i = 60; i < 64; i++) begin
      a = i[mem_pkg::ADDR_WIDTH-1:0];
      host_write(a, {2'b10, a, ~a, 2'b01});
    end
    for (int i = 60; i < 64; i++) begin
      a = i[mem_pkg::ADDR_WIDTH-1:0];
      host_read(a, got);
      check_value(got, {2'b10, a, ~a, 2'b01}, $sformatf("host read back at %0d", a));
    end
  endtask

  task automatic test_patterns();
    logic [booth_pkg::WIDTH-1:0] a;
    logic [booth_pkg::WIDTH-1:0] b;
    for (int i = 0; i < NUM_PAT; i++) begin
      a = pat_mem[5*i+2][booth_pkg::WIDTH-1:0];
      b = pat_mem[5*i+3][booth_pkg::WIDTH-1:0];
      check_value(pat_mem[5*i+4], ref_product(a, b), $sformatf("pattern %0d product", i));
      run_job(pat_mem[5*i][0], pat_mem[5*i+1][mem_pkg::ADDR_WIDTH-1:0], a, b);
    end
  endtask

  task automatic test_latency();
    int cycles;
    load_operands(6'h38, 8'h9c, 8'h37);
    start0 = 1'b1;
    base0  = 6'h38;
    @(posedge clk);
    #5;
    start0 = 1'b0;
    // The edge that took start is the first one counted
    cycles = 1;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      check_value({15'd0, busy0}, 16'd1, "busy0 during an uncontended job");
    end while (!done0 && cycles < 40);
    check_value(16'(cycles), 16'(booth_pkg::WIDTH + 5), "cycles from start to done");
    @(posedge clk);
    #5;
    verify_product(6'h38, ref_product(8'h9c, 8'h37), "product of the timed job");
  endtask

  task automatic test_pair(input logic poll);
    logic [mem_pkg::DATA_WIDTH-1:0] got;
    int t0;
    int t1;
    int reads;
    load_operands(6'h30, 8'h81, 8'h02);
    load_operands(6'h34, 8'h64, 8'h9d);
    t0 = done0_count + 1;
    t1 = done1_count + 1;
    reads = 0;
    start_units(1'b1, 1'b1, 6'h30, 6'h34);
    // Host reads compete with both units for the port
    while (poll && (done0_count < t0 || done1_count < t1)) begin
      host_read(6'h31, got);
      check_value(got, sext_word(8'h02), "operand polled while both units run");
      reads++;
    end
    if (poll) check_value({15'd0, reads > 0}, 16'd1, "host reads during jobs");
    wait_done_counts(t0, t1);
    verify_product(6'h30, ref_product(8'h81, 8'h02), "unit 0 product with both running");
    verify_product(6'h34, ref_product(8'h64, 8'h9d), "unit 1 product with both running");
  endtask

  task automatic test_random();
    logic [31:0]                    rnd;
    logic [mem_pkg::ADDR_WIDTH-1:0] base;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd  = $random(seed);
      base = rnd[21:16];
      if (base > 6'd61) base = base - 6'd2;
      run_job(i[0], base, rnd[7:0], rnd[15:8]);
    end
  endtask

  initial begin
    rst        = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    start0     = 1'b0;
    start1     = 1'b0;
    base0      = '0;
    base1      = '0;
    $readmemh("mul_patterns.txt", pat_mem);
    repeat (8) @(posedge clk);
    #5;
    rst = 1'b1;
    @(negedge clk);
    check_value({15'd0, busy0}, 16'd0, "busy0 after reset");
    check_value({15'd0, busy1}, 16'd0, "busy1 after reset");
    check_value({15'd0, done0}, 16'd0, "done0 after reset");
    check_value({15'd0, done1}, 16'd0, "done1 after reset");
    check_value({15'd0, host_gnt}, 16'd0, "host_gnt after reset");
    @(posedge clk);
    #5;
    test_host_access();
    test_patterns();
    test_latency();
    test_pair(1'b0);
    test_pair(1'b1);
    test_random();
    if (dut.chk.fails == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "assertion failure");
    end
  end

endmodule

`default_nettype wire

/* mul_patterns.txt */
// unit base a b product, all hex; a and b signed 8-bit, product signed 16-bit
// Corner operands on unit 0, the same on unit 1, then mixed signs
0 00 80 80 4000
0 04 80 7f c080
0 08 00 5a 0000
0 0c ff ff 0001
1 10 80 80 4000
1 14 7f 80 c080
1 18 5a 00 0000
1 1c ff ff 0001
0 20 7f 7f 3f01
1 24 03 fd fff7
0 28 0d f6 ff7e
1 2c 01 80 ff80

/* flist.f */
booth_pkg.sv
mem_pkg.sv
booth_controller.sv
booth_datapath.sv
mul_unit.sv
mem_arbiter.sv
operand_ram.sv
mul_subsystem.sv
mul_subsystem_chk.sv
tb_mul_subsystem.sv

/* Makefile */
TOP = tb_mul_subsystem

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

obj_dir/V$(TOP): flist.f *.sv mul_patterns.txt
	verilator --binary --assert --top-module $(TOP) -f flist.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir
